// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache_ctrl
RTL_TOP   ?= dcache_ctrl
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  := TEST RESULT: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl (
	input  logic                  clk_i,
	input  logic                  rst_i,
	// cpu request
	input  logic                  cpu_cyc_i,
	input  logic                  cpu_we_i,
	input  logic                  cpu_erc_i,
	input  dcache_pkg::cpu_tid_t  cpu_tid_i,
	input  dcache_pkg::addr_t     cpu_adr_i,
	input  dcache_pkg::line_sel_t cpu_sel_i,
	input  dcache_pkg::line_dat_t cpu_dat_i,
	output logic                  cpu_busy_o,
	// cpu response
	output logic                  cpu_ack_o,
	output dcache_pkg::cpu_tid_t  cpu_ack_tid_o,
	output dcache_pkg::line_dat_t cpu_ack_dat_o,
	output logic                  cpu_ack_err_o,
	// bus request
	output logic                  bus_cyc_o,
	output logic                  bus_we_o,
	output logic                  bus_erc_o,
	output dcache_pkg::bus_tag_t  bus_tag_o,
	output dcache_pkg::addr_t     bus_adr_o,
	output dcache_pkg::half_sel_t bus_sel_o,
	output dcache_pkg::half_dat_t bus_dat_o,
	input  logic                  bus_full_i,
	// bus response
	input  logic                  bus_ack_i,
	input  dcache_pkg::bus_tag_t  bus_tag_i,
	input  dcache_pkg::half_dat_t bus_dat_i,
	input  logic                  bus_err_i
);
	import dcache_pkg::*;

	// queue to sequencer
	logic      pick_v;
	slot_idx_t pick_slot;
	logic      pick_we;
	logic      pick_erc;
	cpu_tid_t  pick_tid;
	addr_t     pick_adr;
	line_sel_t pick_sel;
	line_dat_t pick_dat;
	logic      take;

	// sequencer to collector
	logic       launch;
	slot_idx_t  launch_slot;
	cpu_tid_t   launch_tid;
	half_mask_t need;
	logic       all_issued;

	// collector back to queue and sequencer
	logic      release_pulse;
	slot_idx_t release_slot;

	dcache_req_queue i_req_queue (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cpu_cyc_i      (cpu_cyc_i),
		.cpu_we_i       (cpu_we_i),
		.cpu_erc_i      (cpu_erc_i),
		.cpu_tid_i      (cpu_tid_i),
		.cpu_adr_i      (cpu_adr_i),
		.cpu_sel_i      (cpu_sel_i),
		.cpu_dat_i      (cpu_dat_i),
		.take_i         (take),
		.release_i      (release_pulse),
		.release_slot_i (release_slot),
		.cpu_busy_o     (cpu_busy_o),
		.pick_v_o       (pick_v),
		.pick_slot_o    (pick_slot),
		.pick_we_o      (pick_we),
		.pick_erc_o     (pick_erc),
		.pick_tid_o     (pick_tid),
		.pick_adr_o     (pick_adr),
		.pick_sel_o     (pick_sel),
		.pick_dat_o     (pick_dat)
	);

	dcache_tran_seq i_tran_seq (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.pick_v_i      (pick_v),
		.pick_slot_i   (pick_slot),
		.pick_we_i     (pick_we),
		.pick_erc_i    (pick_erc),
		.pick_tid_i    (pick_tid),
		.pick_adr_i    (pick_adr),
		.pick_sel_i    (pick_sel),
		.pick_dat_i    (pick_dat),
		.bus_full_i    (bus_full_i),
		.line_done_i   (release_pulse),
		.take_o        (take),
		.launch_o      (launch),
		.launch_slot_o (launch_slot),
		.launch_tid_o  (launch_tid),
		.need_o        (need),
		.all_issued_o  (all_issued),
		.bus_cyc_o     (bus_cyc_o),
		.bus_we_o      (bus_we_o),
		.bus_erc_o     (bus_erc_o),
		.bus_tag_o     (bus_tag_o),
		.bus_adr_o     (bus_adr_o),
		.bus_sel_o     (bus_sel_o),
		.bus_dat_o     (bus_dat_o)
	);

	dcache_resp_collect i_resp_collect (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.launch_i       (launch),
		.launch_slot_i  (launch_slot),
		.launch_tid_i   (launch_tid),
		.need_i         (need),
		.all_issued_i   (all_issued),
		.bus_ack_i      (bus_ack_i),
		.bus_tag_i      (bus_tag_i),
		.bus_dat_i      (bus_dat_i),
		.bus_err_i      (bus_err_i),
		.cpu_ack_o      (cpu_ack_o),
		.cpu_ack_tid_o  (cpu_ack_tid_o),
		.cpu_ack_dat_o  (cpu_ack_dat_o),
		.cpu_ack_err_o  (cpu_ack_err_o),
		.release_o      (release_pulse),
		.release_slot_o (release_slot)
	);

endmodule

// ==== design/dcache_pkg.sv ====
package dcache_pkg;

	// ======================================================================
	// sizes of the request queue and of a cache line
	// ======================================================================

	// request slots held between the cpu and the bus
	localparam int QUEUE_DEPTH = 4;
	localparam int SLOT_W = $clog2(QUEUE_DEPTH);

	// byte address and cpu transaction id widths
	localparam int ADDR_W = 32;
	localparam int CPU_TID_W = 8;

	// a line goes over the bus as two halves
	localparam int LINE_BYTES = 64;
	localparam int HALF_BYTES = 32;
	// address bit that picks the half
	localparam int HALF_BIT = 5;

	// ======================================================================
	// shared types
	// ======================================================================

	typedef logic [SLOT_W-1:0] slot_idx_t;

	// upper bits carry the slot, bit 0 the half
	typedef logic [SLOT_W:0] bus_tag_t;

	typedef logic [CPU_TID_W-1:0] cpu_tid_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// byte selects, one bit per byte
	typedef logic [LINE_BYTES-1:0] line_sel_t;
	typedef logic [HALF_BYTES-1:0] half_sel_t;

	typedef logic [HALF_BYTES*8-1:0] half_dat_t;
	// index 0 is the low half of the line
	typedef half_dat_t [1:0] line_dat_t;

	// one flag per half
	typedef logic [1:0] half_mask_t;

endpackage

// ==== design/dcache_req_queue.sv ====
`timescale 1ns/100ps

module dcache_req_queue (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  cpu_cyc_i,
	input  logic                  cpu_we_i,
	input  logic                  cpu_erc_i,
	input  dcache_pkg::cpu_tid_t  cpu_tid_i,
	input  dcache_pkg::addr_t     cpu_adr_i,
	input  dcache_pkg::line_sel_t cpu_sel_i,
	input  dcache_pkg::line_dat_t cpu_dat_i,
	input  logic                  take_i,
	input  logic                  release_i,
	input  dcache_pkg::slot_idx_t release_slot_i,
	output logic                  cpu_busy_o,
	output logic                  pick_v_o,
	output dcache_pkg::slot_idx_t pick_slot_o,
	output logic                  pick_we_o,
	output logic                  pick_erc_o,
	output dcache_pkg::cpu_tid_t  pick_tid_o,
	output dcache_pkg::addr_t     pick_adr_o,
	output dcache_pkg::line_sel_t pick_sel_o,
	output dcache_pkg::line_dat_t pick_dat_o
);
	import dcache_pkg::*;

	// slot holds a request
	logic [QUEUE_DEPTH-1:0] valid_q;
	// slot handed to the sequencer, not offered again
	logic [QUEUE_DEPTH-1:0] serv_q;

	// request fields per slot
	logic      we_q  [QUEUE_DEPTH];
	logic      erc_q [QUEUE_DEPTH];
	cpu_tid_t  tid_q [QUEUE_DEPTH];
	addr_t     adr_q [QUEUE_DEPTH];
	line_sel_t sel_q [QUEUE_DEPTH];
	line_dat_t dat_q [QUEUE_DEPTH];

	logic      free_v;
	slot_idx_t free_slot;
	logic      dup_hit;
	logic      accept;
	slot_idx_t pick_slot;

	// ======================================================================
	// slot search
	// ======================================================================

	// lowest free slot, scanned downward so the last hit wins
	always_comb begin
		free_v = 1'b0;
		free_slot = '0;
		for (int i = QUEUE_DEPTH-1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				free_v = 1'b1;
				free_slot = slot_idx_t'(i);
			end
		end
	end

	// same tid already waiting or in service
	always_comb begin
		dup_hit = 1'b0;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (valid_q[i] && tid_q[i] == cpu_tid_i)
				dup_hit = 1'b1;
		end
	end

	// a duplicate or a full queue drops the request
	assign accept = cpu_cyc_i && free_v && !dup_hit;
	assign cpu_busy_o = !free_v;

	// lowest slot that is waiting for service
	always_comb begin
		pick_v_o = 1'b0;
		pick_slot = '0;
		for (int i = QUEUE_DEPTH-1; i >= 0; i--) begin
			if (valid_q[i] && !serv_q[i]) begin
				pick_v_o = 1'b1;
				pick_slot = slot_idx_t'(i);
			end
		end
	end

	assign pick_slot_o = pick_slot;
	assign pick_we_o = we_q[pick_slot];
	assign pick_erc_o = erc_q[pick_slot];
	assign pick_tid_o = tid_q[pick_slot];
	assign pick_adr_o = adr_q[pick_slot];
	assign pick_sel_o = sel_q[pick_slot];
	assign pick_dat_o = dat_q[pick_slot];

	// ======================================================================
	// slot state
	// ======================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= '0;
			serv_q <= '0;
		end else begin
			if (accept) begin
				valid_q[free_slot] <= 1'b1;
				serv_q[free_slot] <= 1'b0;
			end
			if (take_i)
				serv_q[pick_slot] <= 1'b1;
			// release only ever hits the slot in service
			if (release_i) begin
				valid_q[release_slot_i] <= 1'b0;
				serv_q[release_slot_i] <= 1'b0;
			end
		end
	end

	// request fields captured on accept
	always_ff @(posedge clk_i) begin
		if (accept) begin
			we_q[free_slot] <= cpu_we_i;
			erc_q[free_slot] <= cpu_erc_i;
			tid_q[free_slot] <= cpu_tid_i;
			adr_q[free_slot] <= cpu_adr_i;
			sel_q[free_slot] <= cpu_sel_i;
			dat_q[free_slot] <= cpu_dat_i;
		end
	end

endmodule

// ==== design/dcache_resp_collect.sv ====
`timescale 1ns/100ps

module dcache_resp_collect (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   launch_i,
	input  dcache_pkg::slot_idx_t  launch_slot_i,
	input  dcache_pkg::cpu_tid_t   launch_tid_i,
	input  dcache_pkg::half_mask_t need_i,
	input  logic                   all_issued_i,
	input  logic                   bus_ack_i,
	input  dcache_pkg::bus_tag_t   bus_tag_i,
	input  dcache_pkg::half_dat_t  bus_dat_i,
	input  logic                   bus_err_i,
	output logic                   cpu_ack_o,
	output dcache_pkg::cpu_tid_t   cpu_ack_tid_o,
	output dcache_pkg::line_dat_t  cpu_ack_dat_o,
	output logic                   cpu_ack_err_o,
	output logic                   release_o,
	output dcache_pkg::slot_idx_t  release_slot_o
);
	import dcache_pkg::*;

	// a request is being collected
	logic       active_q;
	// halves still awaiting a bus ack
	half_mask_t pend_q;
	logic       ack_q;

	slot_idx_t slot_q;
	cpu_tid_t  tid_q;
	line_dat_t line_q;
	logic      err_q;

	slot_idx_t ack_slot;
	logic      ack_half;
	logic      ack_hit;
	logic      done;

	// tag splits into slot and half
	assign ack_slot = bus_tag_i[SLOT_W:1];
	assign ack_half = bus_tag_i[0];

	// stray or repeated acks fall out here
	assign ack_hit = bus_ack_i && active_q && (ack_slot == slot_q) && pend_q[ack_half];

	// everything issued and nothing left to wait for
	assign done = active_q && all_issued_i && (pend_q == '0);

	// ======================================================================
	// collection and completion
	// ======================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			active_q <= 1'b0;
			pend_q <= '0;
			ack_q <= 1'b0;
		end else begin
			// one pulse, active drops on the same edge
			ack_q <= done;
			if (launch_i) begin
				active_q <= 1'b1;
				pend_q <= need_i;
			end else begin
				if (ack_hit)
					pend_q[ack_half] <= 1'b0;
				if (done)
					active_q <= 1'b0;
			end
		end
	end

	// line buffer starts from zero so unrequested halves read back as zero
	always_ff @(posedge clk_i) begin
		if (launch_i) begin
			slot_q <= launch_slot_i;
			tid_q <= launch_tid_i;
			line_q <= '0;
			err_q <= 1'b0;
		end else if (ack_hit) begin
			line_q[ack_half] <= bus_dat_i;
			err_q <= err_q | bus_err_i;
		end
	end

	assign cpu_ack_o = ack_q;
	assign cpu_ack_tid_o = tid_q;
	assign cpu_ack_dat_o = line_q;
	assign cpu_ack_err_o = err_q;

	// the slot is freed on the same cycle as the cpu ack
	assign release_o = ack_q;
	assign release_slot_o = slot_q;

endmodule

// ==== design/dcache_tran_seq.sv ====
`timescale 1ns/100ps

module dcache_tran_seq (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   pick_v_i,
	input  dcache_pkg::slot_idx_t  pick_slot_i,
	input  logic                   pick_we_i,
	input  logic                   pick_erc_i,
	input  dcache_pkg::cpu_tid_t   pick_tid_i,
	input  dcache_pkg::addr_t      pick_adr_i,
	input  dcache_pkg::line_sel_t  pick_sel_i,
	input  dcache_pkg::line_dat_t  pick_dat_i,
	input  logic                   bus_full_i,
	input  logic                   line_done_i,
	output logic                   take_o,
	output logic                   launch_o,
	output dcache_pkg::slot_idx_t  launch_slot_o,
	output dcache_pkg::cpu_tid_t   launch_tid_o,
	output dcache_pkg::half_mask_t need_o,
	output logic                   all_issued_o,
	output logic                   bus_cyc_o,
	output logic                   bus_we_o,
	output logic                   bus_erc_o,
	output dcache_pkg::bus_tag_t   bus_tag_o,
	output dcache_pkg::addr_t      bus_adr_o,
	output dcache_pkg::half_sel_t  bus_sel_o,
	output dcache_pkg::half_dat_t  bus_dat_o
);
	import dcache_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait
	} seq_state_t;

	seq_state_t state_q;

	// request in service
	slot_idx_t slot_q;
	logic      we_q;
	logic      erc_q;
	addr_t     adr_q;
	line_sel_t sel_q;
	line_dat_t dat_q;
	// half on the bus right now
	logic      half_q;

	half_mask_t pick_has;
	logic       upper_has;
	logic       xfer;

	// halves of the picked request with any byte selected
	assign pick_has[0] = |pick_sel_i[HALF_BYTES-1:0];
	assign pick_has[1] = |pick_sel_i[LINE_BYTES-1:HALF_BYTES];
	assign upper_has = |sel_q[LINE_BYTES-1:HALF_BYTES];

	// take only from idle, launch goes out on the same edge
	assign take_o = (state_q == st_idle) && pick_v_i;
	assign launch_o = take_o;
	assign launch_slot_o = pick_slot_i;
	assign launch_tid_o = pick_tid_i;
	// plain writes get no answer, so nothing is awaited for them
	assign need_o = pick_has & {2{!pick_we_i || pick_erc_i}};

	assign xfer = bus_cyc_o && !bus_full_i;

	// ======================================================================
	// sequencing FSM
	// ======================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: begin
					// a request with no selects skips the bus entirely
					if (take_o)
						state_q <= (|pick_has) ? st_issue : st_wait;
				end
				st_issue: begin
					if (xfer && (half_q || !upper_has))
						state_q <= st_wait;
				end
				st_wait: begin
					// collector has acked the cpu
					if (line_done_i)
						state_q <= st_idle;
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (take_o) begin
			slot_q <= pick_slot_i;
			we_q <= pick_we_i;
			erc_q <= pick_erc_i;
			adr_q <= pick_adr_i;
			sel_q <= pick_sel_i;
			dat_q <= pick_dat_i;
			// start at the upper half when the lower one is empty
			half_q <= !pick_has[0];
		end else if (xfer) begin
			half_q <= 1'b1;
		end
	end

	// ======================================================================
	// bus request
	// ======================================================================

	// all fields come from registers and hold while the bus is full
	assign bus_cyc_o = (state_q == st_issue);
	assign bus_we_o = we_q;
	assign bus_erc_o = erc_q;
	assign bus_tag_o = {slot_q, half_q};
	assign bus_adr_o = {adr_q[ADDR_W-1:HALF_BIT+1], half_q, {HALF_BIT{1'b0}}};
	assign bus_sel_o = half_q ? sel_q[LINE_BYTES-1:HALF_BYTES] : sel_q[HALF_BYTES-1:0];
	assign bus_dat_o = dat_q[half_q];

	assign all_issued_o = (state_q == st_wait);

endmodule

// ==== sim/tb_dcache_ctrl.sv ====
`timescale 1ns/100ps

module tb_dcache_ctrl;
	import dcache_pkg::*;

	localparam int NUM_ROWS = 11;
	localparam int HOLD_CYCLES = 60;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 400;

	logic      clk_i;
	logic      rst_i;
	logic      cpu_cyc_i;
	logic      cpu_we_i;
	logic      cpu_erc_i;
	cpu_tid_t  cpu_tid_i;
	addr_t     cpu_adr_i;
	line_sel_t cpu_sel_i;
	line_dat_t cpu_dat_i;
	logic      cpu_busy_o;
	logic      cpu_ack_o;
	cpu_tid_t  cpu_ack_tid_o;
	line_dat_t cpu_ack_dat_o;
	logic      cpu_ack_err_o;
	logic      bus_cyc_o;
	logic      bus_we_o;
	logic      bus_erc_o;
	bus_tag_t  bus_tag_o;
	addr_t     bus_adr_o;
	half_sel_t bus_sel_o;
	half_dat_t bus_dat_o;
	logic      bus_full_i;
	logic      bus_ack_i;
	bus_tag_t  bus_tag_i;
	half_dat_t bus_dat_i;
	logic      bus_err_i;

	// stimulus table
	cpu_tid_t  row_tid [NUM_ROWS];
	logic      row_we  [NUM_ROWS];
	logic      row_erc [NUM_ROWS];
	addr_t     row_adr [NUM_ROWS];
	line_sel_t row_sel [NUM_ROWS];
	// row repeats a tid that is still queued
	logic      row_dup [NUM_ROWS];

	// scoreboard, indexed by cpu tid
	logic exp_pend   [256];
	int   exp_row    [256];
	int   got_xfers  [256];
	int   first_slot [256];
	// bus responses not yet returned by the memory model
	int   open_rsp   [256];

	int     acks_seen;
	int     acks_expected;
	int     mism_cnt;
	int     fail_cnt;
	int     cycle;
	integer seed;
	logic   hold_full;

	// bus responses waiting for their delay to run out
	bus_tag_t  rsp_tag_q [$];
	half_dat_t rsp_dat_q [$];
	logic      rsp_err_q [$];
	int        rsp_due_q [$];
	cpu_tid_t  rsp_tid_q [$];

	// request seen while the bus was full
	logic      held_prev;
	logic      prev_we;
	logic      prev_erc;
	bus_tag_t  prev_tag;
	addr_t     prev_adr;
	half_sel_t prev_sel;
	half_dat_t prev_dat;

	dcache_ctrl i_dut (.*);

	// ======================================================================
	// clock, watchdog
	// ======================================================================

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ======================================================================
	// reference rules
	// ======================================================================

	// cpu write data, every word distinct per tid, half and word
	function automatic line_dat_t fill_line(cpu_tid_t tid);
		line_dat_t l;
		for (int h = 0; h < 2; h++)
			for (int w = 0; w < 8; w++)
				l[h][w*32 +: 32] = 32'hc0de0000 ^ {tid, 24'h0} ^ 32'(h*8 + w);
		return l;
	endfunction

	// memory content, each word is its byte address xor a constant
	function automatic half_dat_t mem_pattern(addr_t base);
		half_dat_t d;
		for (int w = 0; w < 8; w++)
			d[w*32 +: 32] = (base + 32'(w*4)) ^ 32'h5a5a0000;
		return d;
	endfunction

	function automatic half_sel_t sel_half(line_sel_t s, int h);
		return (h != 0) ? s[63:32] : s[31:0];
	endfunction

	function automatic int count_halves(line_sel_t s);
		return int'(|s[31:0]) + int'(|s[63:32]);
	endfunction

	// reads return memory in selected halves, writes return zero
	function automatic line_dat_t expect_line(int r);
		line_dat_t l;
		l = '0;
		if (!row_we[r])
			for (int h = 0; h < 2; h++)
				if (|sel_half(row_sel[r], h))
					l[h] = mem_pattern({row_adr[r][31:6], 1'(h), 5'b0});
		return l;
	endfunction

	// error only when some half is answered from an E address
	function automatic logic expect_err(int r);
		return (!row_we[r] || row_erc[r]) && (|row_sel[r]) && (row_adr[r][31:28] == 4'he);
	endfunction

	// ======================================================================
	// reporting
	// ======================================================================

	task automatic report_mismatch(string name, logic [511:0] got, logic [511:0] exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		mism_cnt++;
	endtask

	task automatic report_failure(string msg);
		$display("Error at %0t: %s", $time, msg);
		fail_cnt++;
	endtask

	// ======================================================================
	// table and stimulus
	// ======================================================================

	task automatic set_row(int r, cpu_tid_t tid, logic we, logic erc, addr_t adr,
			line_sel_t sel, logic dup);
		row_tid[r] = tid;
		row_we[r] = we;
		row_erc[r] = erc;
		row_adr[r] = adr;
		row_sel[r] = sel;
		row_dup[r] = dup;
	endtask

	task automatic load_table();
		// full read, upper half read, plain write, erc write
		set_row(0, 8'h11, 1'b0, 1'b0, 32'h10000040, {64{1'b1}}, 1'b0);
		set_row(1, 8'h12, 1'b0, 1'b0, 32'h10000080, {32'hffffffff, 32'h0}, 1'b0);
		set_row(2, 8'h13, 1'b1, 1'b0, 32'h200000c0, 64'h00f0_0000_0000_ff0f, 1'b0);
		set_row(3, 8'h14, 1'b1, 1'b1, 32'h20000100, 64'h0000_0001_8000_0000, 1'b0);
		// lower half read then the same tid again
		set_row(4, 8'h15, 1'b0, 1'b0, 32'h10000140, 64'h0000_0000_ffff_0000, 1'b0);
		set_row(5, 8'h15, 1'b0, 1'b0, 32'h10000140, 64'h0000_0000_ffff_0000, 1'b1);
		// bus error area
		set_row(6, 8'h16, 1'b0, 1'b0, 32'he0000180, {64{1'b1}}, 1'b0);
		// fills the queue while the bus is full
		set_row(7, 8'h21, 1'b0, 1'b0, 32'h30000000, {64{1'b1}}, 1'b0);
		set_row(8, 8'h22, 1'b1, 1'b0, 32'h30000040, 64'h0300_0000_0000_00c0, 1'b0);
		set_row(9, 8'h23, 1'b1, 1'b1, 32'h30000080, {64{1'b1}}, 1'b0);
		set_row(10, 8'h24, 1'b0, 1'b0, 32'he00001c0, {32'hffffffff, 32'h0}, 1'b0);
	endtask

	// called at a falling edge, returns at the falling edge after the pulse
	task automatic issue_row(int r);
		cpu_tid_t t;
		t = row_tid[r];
		while (cpu_busy_o)
			@(negedge clk_i);
		cpu_cyc_i = 1'b1;
		cpu_we_i = row_we[r];
		cpu_erc_i = row_erc[r];
		cpu_tid_i = t;
		cpu_adr_i = row_adr[r];
		cpu_sel_i = row_sel[r];
		cpu_dat_i = fill_line(t);
		if (!row_dup[r]) begin
			exp_pend[t] = 1'b1;
			exp_row[t] = r;
			got_xfers[t] = 0;
			first_slot[t] = -1;
			open_rsp[t] = 0;
			acks_expected++;
		end
		@(negedge clk_i);
		cpu_cyc_i = 1'b0;
	endtask

	task automatic wait_drain();
		while (acks_seen < acks_expected)
			@(negedge clk_i);
	endtask

	// ======================================================================
	// bus monitor and scoreboard
	// ======================================================================

	task automatic check_stable();
		if (held_prev) begin
			assert (bus_cyc_o && bus_we_o == prev_we && bus_erc_o == prev_erc &&
					bus_tag_o == prev_tag && bus_adr_o == prev_adr &&
					bus_sel_o == prev_sel && bus_dat_o == prev_dat)
			else report_failure("bus request changed while bus_full_i was high");
		end
		held_prev = bus_cyc_o && bus_full_i;
		prev_we = bus_we_o;
		prev_erc = bus_erc_o;
		prev_tag = bus_tag_o;
		prev_adr = bus_adr_o;
		prev_sel = bus_sel_o;
		prev_dat = bus_dat_o;
	endtask

	task automatic record_transfer();
		int        r;
		int        h;
		cpu_tid_t  t;
		logic      found;
		line_dat_t wdat;
		addr_t     exp_adr;
		found = 1'b0;
		r = 0;
		h = 0;
		t = '0;
		$display("%0t: transfer tag %0d adr %h we %b erc %b sel %h", $time, bus_tag_o,
			bus_adr_o, bus_we_o, bus_erc_o, bus_sel_o);
		// owner found by line address, lines are unique among pending rows
		for (int i = 0; i < 256; i++) begin
			if (exp_pend[i] && row_adr[exp_row[i]][31:6] == bus_adr_o[31:6]) begin
				found = 1'b1;
				t = cpu_tid_t'(i);
				r = exp_row[i];
			end
		end
		assert (found)
		else report_failure($sformatf("bus transfer to %h belongs to no pending request",
			bus_adr_o));
		if (found) begin
			// lower half goes first unless it has no selects
			h = (got_xfers[t] == 0 && |row_sel[r][31:0]) ? 0 : 1;
			exp_adr = {row_adr[r][31:6], 1'(h), 5'b0};
			wdat = fill_line(t);
			assert (bus_tag_o[0] == 1'(h))
			else report_mismatch("bus_tag_o half", 512'(bus_tag_o[0]), 512'(h));
			assert (bus_adr_o == exp_adr)
			else report_mismatch("bus_adr_o", 512'(bus_adr_o), 512'(exp_adr));
			assert (bus_sel_o == sel_half(row_sel[r], h) && |bus_sel_o)
			else report_mismatch("bus_sel_o", 512'(bus_sel_o), 512'(sel_half(row_sel[r], h)));
			assert (bus_we_o == row_we[r] && bus_erc_o == row_erc[r])
			else report_mismatch("bus_we_o/bus_erc_o", 512'({bus_we_o, bus_erc_o}),
				512'({row_we[r], row_erc[r]}));
			if (row_we[r]) begin
				assert (bus_dat_o == wdat[h])
				else report_mismatch("bus_dat_o", 512'(bus_dat_o), 512'(wdat[h]));
			end
			// both halves of one request carry the same slot
			if (first_slot[t] < 0)
				first_slot[t] = int'(bus_tag_o[2:1]);
			assert (first_slot[t] == int'(bus_tag_o[2:1]))
			else report_mismatch("bus_tag_o slot", 512'(bus_tag_o[2:1]), 512'(first_slot[t]));
			got_xfers[t]++;
		end
		// plain writes are never answered
		if (!bus_we_o || bus_erc_o) begin
			rsp_tid_q.push_back(t);
			open_rsp[t]++;
			rsp_tag_q.push_back(bus_tag_o);
			rsp_dat_q.push_back(bus_we_o ? '0 : mem_pattern(bus_adr_o));
			rsp_err_q.push_back(bus_adr_o[31:28] == 4'he);
			rsp_due_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 6));
		end
	endtask

	task automatic check_ack();
		cpu_tid_t t;
		int       r;
		t = cpu_ack_tid_o;
		assert (exp_pend[t])
		else report_failure($sformatf("cpu ack for tid %h with no pending request", t));
		if (exp_pend[t]) begin
			r = exp_row[t];
			assert (cpu_ack_dat_o == expect_line(r))
			else report_mismatch("cpu_ack_dat_o", 512'(cpu_ack_dat_o), 512'(expect_line(r)));
			assert (cpu_ack_err_o == expect_err(r))
			else report_mismatch("cpu_ack_err_o", 512'(cpu_ack_err_o), 512'(expect_err(r)));
			assert (got_xfers[t] == count_halves(row_sel[r]))
			else report_mismatch("bus transfer count", 512'(got_xfers[t]),
				512'(count_halves(row_sel[r])));
			assert (open_rsp[t] == 0)
			else report_failure($sformatf("cpu ack for tid %h came before its bus acks", t));
			exp_pend[t] = 1'b0;
			acks_seen++;
		end
	endtask

	always @(posedge clk_i) begin
		cycle++;
		if (!rst_i) begin
			check_stable();
			if (bus_cyc_o && !bus_full_i)
				record_transfer();
			if (cpu_ack_o)
				check_ack();
		end
	end

	// memory side, driven on the falling edge
	always @(negedge clk_i) begin : drive_bus
		int idx;
		idx = -1;
		// oldest response whose delay has run out
		for (int i = rsp_due_q.size() - 1; i >= 0; i--)
			if (rsp_due_q[i] <= cycle)
				idx = i;
		bus_ack_i = 1'b0;
		bus_tag_i = '0;
		bus_dat_i = '0;
		bus_err_i = 1'b0;
		if (rst_i)
			bus_full_i = 1'b0;
		else
			bus_full_i = hold_full || (($random(seed) & 3) == 0);
		if (idx >= 0) begin
			bus_ack_i = 1'b1;
			bus_tag_i = rsp_tag_q[idx];
			bus_dat_i = rsp_dat_q[idx];
			bus_err_i = rsp_err_q[idx];
			open_rsp[rsp_tid_q[idx]]--;
			rsp_tag_q.delete(idx);
			rsp_dat_q.delete(idx);
			rsp_err_q.delete(idx);
			rsp_due_q.delete(idx);
			rsp_tid_q.delete(idx);
		end
	end

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		seed = 32'hf04d2ea9;
		rst_i = 1'b1;
		cpu_cyc_i = 1'b0;
		cpu_we_i = 1'b0;
		cpu_erc_i = 1'b0;
		cpu_tid_i = '0;
		cpu_adr_i = '0;
		cpu_sel_i = '0;
		cpu_dat_i = '0;
		bus_full_i = 1'b0;
		bus_ack_i = 1'b0;
		bus_tag_i = '0;
		bus_dat_i = '0;
		bus_err_i = 1'b0;
		hold_full = 1'b0;
		held_prev = 1'b0;
		acks_seen = 0;
		acks_expected = 0;
		mism_cnt = 0;
		fail_cnt = 0;
		cycle = 0;
		for (int i = 0; i < 256; i++) begin
			exp_pend[i] = 1'b0;
			open_rsp[i] = 0;
		end
		load_table();
		repeat (10) @(negedge clk_i);
		rst_i = 1'b0;
		repeat (2) @(negedge clk_i);
		for (int r = 0; r < 7; r++)
			issue_row(r);
		wait_drain();
		// bus stalled, the queue must fill up and report busy
		hold_full = 1'b1;
		for (int r = 7; r < NUM_ROWS; r++)
			issue_row(r);
		@(negedge clk_i);
		assert (cpu_busy_o)
		else report_failure("cpu_busy_o stayed low with four requests queued");
		repeat (HOLD_CYCLES) @(negedge clk_i);
		hold_full = 1'b0;
		wait_drain();
		repeat (20) @(negedge clk_i);
		$display("errors: %0d mismatches, %0d other failures, %0d of %0d acks", mism_cnt,
			fail_cnt, acks_seen, acks_expected);
		if (mism_cnt == 0 && fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
design/dcache_pkg.sv
design/dcache_req_queue.sv
design/dcache_tran_seq.sv
design/dcache_resp_collect.sv
design/dcache_ctrl.sv
sim/tb_dcache_ctrl.sv
